// File: src/fuse_ss_pkg.sv
// Fuse subsystem package with service opcodes, clock select, fault mode, FSM states and ECC widths
`default_nettype none

package fuse_ss_pkg;

  // ----------------------------------------------------------
  // Fuse word geometry
  // ----------------------------------------------------------
  localparam int DATA_W = 16;
  localparam int ECC_W  = 6;
  localparam int CODE_W = DATA_W + ECC_W;

  // Defaults handed down from the top level
  localparam int NUM_PARTS   = 4;
  localparam int PART_WORDS  = 8;
  localparam int CMD_CREDITS = 4;
  localparam int RST_CYCLES  = 10;

  // ----------------------------------------------------------
  // Encodings
  // ----------------------------------------------------------
  // Any service code outside this list is popped and ignored
  typedef enum logic [7:0] {
    NOP                 = 8'h00,
    DOMAIN_RESET        = 8'h10,
    FAULT_CORRECTABLE   = 8'h20,
    FAULT_UNCORRECTABLE = 8'h21,
    FAULT_CLEAR         = 8'h22,
    CLK_160             = 8'h30,
    CLK_400             = 8'h31,
    CLK_500             = 8'h32,
    CLK_1000            = 8'h33,
    ESCALATE            = 8'h40
  } svc_cmd_e;

  typedef enum logic [1:0] {
    MHZ_160  = 2'd0,
    MHZ_400  = 2'd1,
    MHZ_500  = 2'd2,
    MHZ_1000 = 2'd3
  } clk_sel_e;

  typedef enum logic [1:0] {
    NONE          = 2'd0,
    CORRECTABLE   = 2'd1,
    UNCORRECTABLE = 2'd2
  } fault_mode_e;

  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    READ    = 3'd1,
    DECODE  = 3'd2,
    PROGRAM = 3'd3,
    SCRAP   = 3'd4
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: src/svc_cmd_decoder.sv
// Service command decoder with credit FIFO, domain reset timer, fault mode and clock switch
`default_nettype none

module svc_cmd_decoder #(
  parameter int CMD_CREDITS = fuse_ss_pkg::CMD_CREDITS,
  parameter int RST_CYCLES  = fuse_ss_pkg::RST_CYCLES
) (
  input  logic                     clk,
  input  logic                     cptra_rst_b,
  input  logic                     cmd_valid_i,
  input  fuse_ss_pkg::svc_cmd_e    cmd_i,
  input  logic                     clk_byp_ack_i,
  output logic                     cmd_credit_o,
  output logic                     domain_rst_active_o,
  output fuse_ss_pkg::fault_mode_e fault_mode_o,
  output logic                     escalate_o,
  output fuse_ss_pkg::clk_sel_e    clk_sel_o,
  output logic                     clk_switch_req_o
);

  localparam int PTR_W = (CMD_CREDITS > 1) ? $clog2(CMD_CREDITS) : 1;
  localparam int CNT_W = $clog2(CMD_CREDITS + 1);
  localparam int TMR_W = $clog2(RST_CYCLES + 1);

  fuse_ss_pkg::svc_cmd_e fifo_mem [CMD_CREDITS];
  fuse_ss_pkg::svc_cmd_e head;
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;
  logic [TMR_W-1:0]      rst_cnt;
  logic                  pop;

  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
    return (p == PTR_W'(CMD_CREDITS - 1)) ? '0 : p + 1'b1;
  endfunction

  // ----------------------------------------------------------
  // Command FIFO with one entry per host credit
  // ----------------------------------------------------------
  // Nothing leaves the queue while the domain reset runs, so credits are withheld
  assign head         = fifo_mem[rd_ptr];
  assign pop          = (count != '0) && !domain_rst_active_o;
  assign cmd_credit_o = pop;

  always_ff @(posedge clk) begin
    if (cmd_valid_i) begin
      fifo_mem[wr_ptr] <= cmd_i;
    end
  end

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (cmd_valid_i) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count <= count + CNT_W'(cmd_valid_i) - CNT_W'(pop);
    end
  end

  // ----------------------------------------------------------
  // Command execution
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      domain_rst_active_o <= 1'b0;
      rst_cnt             <= '0;
      fault_mode_o        <= fuse_ss_pkg::NONE;
      escalate_o          <= 1'b0;
      clk_sel_o           <= fuse_ss_pkg::MHZ_1000;
      clk_switch_req_o    <= 1'b0;
    end else begin
      // The reset stays active for RST_CYCLES+1 cycles while the timer counts up to RST_CYCLES
      if (domain_rst_active_o) begin
        if (rst_cnt == TMR_W'(RST_CYCLES)) begin
          domain_rst_active_o <= 1'b0;
        end else begin
          rst_cnt <= rst_cnt + 1'b1;
        end
      end

      // The request drops once the acknowledge is seen at an edge
      if (clk_switch_req_o && clk_byp_ack_i) begin
        clk_switch_req_o <= 1'b0;
      end

      if (pop) begin
        case (head)
          fuse_ss_pkg::DOMAIN_RESET: begin
            domain_rst_active_o <= 1'b1;
            rst_cnt             <= '0;
            fault_mode_o        <= fuse_ss_pkg::NONE;
            escalate_o          <= 1'b0;
          end
          fuse_ss_pkg::FAULT_CORRECTABLE: begin
            if (fault_mode_o == fuse_ss_pkg::NONE) begin
              fault_mode_o <= fuse_ss_pkg::CORRECTABLE;
            end
          end
          fuse_ss_pkg::FAULT_UNCORRECTABLE: begin
            if (fault_mode_o == fuse_ss_pkg::NONE) begin
              fault_mode_o <= fuse_ss_pkg::UNCORRECTABLE;
            end
          end
          fuse_ss_pkg::FAULT_CLEAR: fault_mode_o <= fuse_ss_pkg::NONE;
          fuse_ss_pkg::CLK_160: begin
            clk_sel_o        <= fuse_ss_pkg::MHZ_160;
            clk_switch_req_o <= 1'b1;
          end
          fuse_ss_pkg::CLK_400: begin
            clk_sel_o        <= fuse_ss_pkg::MHZ_400;
            clk_switch_req_o <= 1'b1;
          end
          fuse_ss_pkg::CLK_500: begin
            clk_sel_o        <= fuse_ss_pkg::MHZ_500;
            clk_switch_req_o <= 1'b1;
          end
          fuse_ss_pkg::CLK_1000: begin
            clk_sel_o        <= fuse_ss_pkg::MHZ_1000;
            clk_switch_req_o <= 1'b1;
          end
          fuse_ss_pkg::ESCALATE: escalate_o <= 1'b1;
          default: begin
            // NOP and unknown codes only give the credit back
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: src/otp_ecc_codec.sv
// SECDED encoder and decoder for 16-bit fuse words with 6 check bits
`default_nettype none

module otp_ecc_codec (
  input  logic [fuse_ss_pkg::DATA_W-1:0] enc_data_i,
  input  logic [fuse_ss_pkg::CODE_W-1:0] dec_code_i,
  output logic [fuse_ss_pkg::CODE_W-1:0] enc_code_o,
  output logic [fuse_ss_pkg::DATA_W-1:0] dec_data_o,
  output logic                           dec_corr_o,
  output logic                           dec_uncorr_o
);

  // Bits 1..CODE_W-1 follow Hamming positions and bit 0 holds overall parity
  localparam int CODE_W = fuse_ss_pkg::CODE_W;
  localparam int HAM_W  = fuse_ss_pkg::ECC_W - 1;

  always_comb begin : encode
    logic [CODE_W-1:0] code;
    logic              par;
    int                d;
    code = '0;
    d    = 0;
    // Data fills every position that is not a power of two
    for (int i = 1; i < CODE_W; i++) begin
      if ((i & (i - 1)) != 0) begin
        code[i] = enc_data_i[d];
        d++;
      end
    end
    for (int p = 0; p < HAM_W; p++) begin
      par = 1'b0;
      for (int i = 1; i < CODE_W; i++) begin
        if (((i >> p) & 1) != 0 && (i & (i - 1)) != 0) begin
          par = par ^ code[i];
        end
      end
      code[1 << p] = par;
    end
    code[0]    = ^code[CODE_W-1:1];
    enc_code_o = code;
  end

  always_comb begin : decode
    logic [CODE_W-1:0] fixed;
    logic [HAM_W-1:0]  syn;
    int                d;
    syn = '0;
    for (int i = 1; i < CODE_W; i++) begin
      for (int p = 0; p < HAM_W; p++) begin
        if (((i >> p) & 1) != 0) begin
          syn[p] = syn[p] ^ dec_code_i[i];
        end
      end
    end

    fixed        = dec_code_i;
    dec_corr_o   = 1'b0;
    dec_uncorr_o = 1'b0;
    if (^dec_code_i) begin
      // Odd parity means one flip and a zero syndrome points at bit 0 itself
      if (int'(syn) < CODE_W) begin
        fixed[syn] = ~fixed[syn];
        dec_corr_o = 1'b1;
      end else begin
        dec_uncorr_o = 1'b1;
      end
    end else if (syn != '0) begin
      dec_uncorr_o = 1'b1;
    end

    d          = 0;
    dec_data_o = '0;
    for (int i = 1; i < CODE_W; i++) begin
      if ((i & (i - 1)) != 0) begin
        dec_data_o[d] = fixed[i];
        d++;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/otp_fuse_array.sv
// OTP codeword storage with OR-only programming, registered read and readout fault injection
`default_nettype none

module otp_fuse_array #(
  parameter int  NUM_PARTS  = fuse_ss_pkg::NUM_PARTS,
  parameter int  PART_WORDS = fuse_ss_pkg::PART_WORDS,
  localparam int ADDR_W     = $clog2(NUM_PARTS * PART_WORDS)
) (
  input  logic                           clk,
  input  logic                           cptra_rst_b,
  input  logic                           wr_en_i,
  input  logic [ADDR_W-1:0]              wr_addr_i,
  input  logic [fuse_ss_pkg::CODE_W-1:0] wr_code_i,
  input  logic                           rd_en_i,
  input  logic [ADDR_W-1:0]              rd_addr_i,
  input  fuse_ss_pkg::fault_mode_e       fault_mode_i,
  input  logic [NUM_PARTS-1:0]           part_locked_i,
  output logic [fuse_ss_pkg::CODE_W-1:0] rd_code_o
);

  localparam int DEPTH  = NUM_PARTS * PART_WORDS;
  localparam int PART_W = (NUM_PARTS > 1) ? $clog2(NUM_PARTS) : 1;

  logic [fuse_ss_pkg::CODE_W-1:0] mem [DEPTH];
  logic [fuse_ss_pkg::CODE_W-1:0] fault_mask;
  logic [PART_W-1:0]              rd_part;
  logic                           rd_first_word;

  assign rd_part       = PART_W'(rd_addr_i / ADDR_W'(PART_WORDS));
  assign rd_first_word = (rd_addr_i % ADDR_W'(PART_WORDS)) == '0;

  // Only the first word of a locked partition is disturbed, and only on its way out
  always_comb begin
    fault_mask = '0;
    if (rd_first_word && part_locked_i[rd_part]) begin
      case (fault_mode_i)
        fuse_ss_pkg::CORRECTABLE:   fault_mask[0]   = 1'b1;
        fuse_ss_pkg::UNCORRECTABLE: fault_mask[1:0] = 2'b11;
        default:                    fault_mask      = '0;
      endcase
    end
  end

  // Power-on leaves every fuse unblown
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
      rd_code_o <= '0;
    end else begin
      // A fuse can be blown but never restored
      if (wr_en_i) begin
        mem[wr_addr_i] <= mem[wr_addr_i] | wr_code_i;
      end
      if (rd_en_i) begin
        rd_code_o <= mem[rd_addr_i] ^ fault_mask;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/fuse_partition_ctrl.sv
// Fuse partition controller FSM with lock tracking, ECC status and scrap handling
`default_nettype none

module fuse_partition_ctrl #(
  parameter int  NUM_PARTS  = fuse_ss_pkg::NUM_PARTS,
  parameter int  PART_WORDS = fuse_ss_pkg::PART_WORDS,
  localparam int ADDR_W     = $clog2(NUM_PARTS * PART_WORDS)
) (
  input  logic                           clk,
  input  logic                           cptra_rst_b,
  input  logic                           domain_rst_i,
  input  logic                           escalate_i,
  input  logic                           req_i,
  input  logic                           req_write_i,
  input  logic [ADDR_W-1:0]              addr_i,
  input  logic [fuse_ss_pkg::DATA_W-1:0] wdata_i,
  input  logic [fuse_ss_pkg::CODE_W-1:0] enc_code_i,
  input  logic [fuse_ss_pkg::DATA_W-1:0] dec_data_i,
  input  logic                           dec_corr_i,
  input  logic                           dec_uncorr_i,
  output logic                           arr_wr_en_o,
  output logic [ADDR_W-1:0]              arr_addr_o,
  output logic [fuse_ss_pkg::CODE_W-1:0] arr_wr_code_o,
  output logic                           arr_rd_en_o,
  output logic [NUM_PARTS-1:0]           part_locked_o,
  output logic [fuse_ss_pkg::DATA_W-1:0] enc_data_o,
  output logic                           busy_o,
  output logic                           rd_valid_o,
  output logic [fuse_ss_pkg::DATA_W-1:0] rdata_o,
  output logic                           corr_err_o,
  output logic                           uncorr_err_o,
  output logic                           scrap_o
);

  localparam int PART_W = (NUM_PARTS > 1) ? $clog2(NUM_PARTS) : 1;

  fuse_ss_pkg::ctrl_state_e       state;
  fuse_ss_pkg::ctrl_state_e       rest_state;
  logic [ADDR_W-1:0]              addr_q;
  logic [fuse_ss_pkg::DATA_W-1:0] wdata_q;
  logic [NUM_PARTS-1:0]           lock_q;
  logic                           scrap_q;
  logic [PART_W-1:0]              part_idx;
  logic                           is_digest;
  logic                           wr_allowed;
  logic                           accept;

  assign part_idx   = PART_W'(addr_q / ADDR_W'(PART_WORDS));
  assign is_digest  = (addr_q % ADDR_W'(PART_WORDS)) == ADDR_W'(PART_WORDS - 1);
  assign wr_allowed = !lock_q[part_idx] && !scrap_q;

  // SCRAP is the resting state once escalation has been seen
  assign rest_state = (scrap_q || escalate_i) ? fuse_ss_pkg::SCRAP : fuse_ss_pkg::IDLE;
  assign accept     = req_i && !domain_rst_i &&
                      (state == fuse_ss_pkg::IDLE || state == fuse_ss_pkg::SCRAP);

  assign arr_addr_o    = addr_q;
  assign arr_rd_en_o   = (state == fuse_ss_pkg::READ);
  assign arr_wr_en_o   = (state == fuse_ss_pkg::PROGRAM) && wr_allowed;
  assign arr_wr_code_o = enc_code_i;
  assign enc_data_o    = wdata_q;
  assign part_locked_o = lock_q;
  assign scrap_o       = scrap_q;

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
  end

  // ----------------------------------------------------------
  // Request FSM
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      state        <= fuse_ss_pkg::IDLE;
      busy_o       <= 1'b0;
      rd_valid_o   <= 1'b0;
      rdata_o      <= '0;
      corr_err_o   <= 1'b0;
      uncorr_err_o <= 1'b0;
      scrap_q      <= 1'b0;
      lock_q       <= '0;
    end else if (domain_rst_i) begin
      // Locks mirror blown digests, so they outlive the domain reset
      state        <= fuse_ss_pkg::IDLE;
      busy_o       <= 1'b0;
      rd_valid_o   <= 1'b0;
      corr_err_o   <= 1'b0;
      uncorr_err_o <= 1'b0;
      scrap_q      <= 1'b0;
    end else begin
      rd_valid_o <= 1'b0;
      if (escalate_i) begin
        scrap_q <= 1'b1;
      end
      case (state)
        fuse_ss_pkg::IDLE, fuse_ss_pkg::SCRAP: begin
          if (accept) begin
            busy_o <= 1'b1;
            state  <= req_write_i ? fuse_ss_pkg::PROGRAM : fuse_ss_pkg::READ;
          end else begin
            state <= rest_state;
          end
        end
        fuse_ss_pkg::READ: state <= fuse_ss_pkg::DECODE;
        fuse_ss_pkg::DECODE: begin
          busy_o     <= 1'b0;
          rd_valid_o <= 1'b1;
          state      <= rest_state;
          if (scrap_q) begin
            rdata_o      <= '0;
            corr_err_o   <= 1'b0;
            uncorr_err_o <= 1'b1;
          end else begin
            rdata_o      <= dec_data_i;
            corr_err_o   <= dec_corr_i;
            uncorr_err_o <= dec_uncorr_i;
            if (is_digest && dec_data_i != '0) begin
              lock_q[part_idx] <= 1'b1;
            end
          end
        end
        fuse_ss_pkg::PROGRAM: begin
          busy_o <= 1'b0;
          state  <= rest_state;
          if (wr_allowed && is_digest && wdata_q != '0) begin
            lock_q[part_idx] <= 1'b1;
          end
        end
        default: state <= fuse_ss_pkg::IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/fuse_ss_top.sv
// Fuse subsystem top level joining command decoder, partition controller, array and codec
`default_nettype none

module fuse_ss_top #(
  parameter int  NUM_PARTS   = fuse_ss_pkg::NUM_PARTS,
  parameter int  PART_WORDS  = fuse_ss_pkg::PART_WORDS,
  parameter int  CMD_CREDITS = fuse_ss_pkg::CMD_CREDITS,
  parameter int  RST_CYCLES  = fuse_ss_pkg::RST_CYCLES,
  localparam int ADDR_W      = $clog2(NUM_PARTS * PART_WORDS)
) (
  input  logic                           clk,
  input  logic                           cptra_rst_b,
  // Service commands
  input  logic                           cmd_valid_i,
  input  fuse_ss_pkg::svc_cmd_e          cmd_i,
  output logic                           cmd_credit_o,
  // Fuse reads and programs
  input  logic                           req_i,
  input  logic                           req_write_i,
  input  logic [ADDR_W-1:0]              addr_i,
  input  logic [fuse_ss_pkg::DATA_W-1:0] wdata_i,
  output logic                           busy_o,
  output logic                           rd_valid_o,
  output logic [fuse_ss_pkg::DATA_W-1:0] rdata_o,
  output logic                           corr_err_o,
  output logic                           uncorr_err_o,
  output logic                           scrap_o,
  // Clock and reset control
  output fuse_ss_pkg::clk_sel_e          clk_sel_o,
  output logic                           clk_switch_req_o,
  input  logic                           clk_byp_ack_i,
  output logic                           domain_rst_active_o
);

  fuse_ss_pkg::fault_mode_e       fault_mode;
  logic                           escalate;
  logic                           arr_wr_en;
  logic                           arr_rd_en;
  logic [ADDR_W-1:0]              arr_addr;
  logic [fuse_ss_pkg::CODE_W-1:0] arr_wr_code;
  logic [fuse_ss_pkg::CODE_W-1:0] arr_rd_code;
  logic [NUM_PARTS-1:0]           part_locked;
  logic [fuse_ss_pkg::DATA_W-1:0] enc_data;
  logic [fuse_ss_pkg::CODE_W-1:0] enc_code;
  logic [fuse_ss_pkg::DATA_W-1:0] dec_data;
  logic                           dec_corr;
  logic                           dec_uncorr;

  svc_cmd_decoder #(
    .CMD_CREDITS (CMD_CREDITS),
    .RST_CYCLES  (RST_CYCLES)
  ) u_svc_cmd_decoder (
    .clk                 (clk),
    .cptra_rst_b         (cptra_rst_b),
    .cmd_valid_i         (cmd_valid_i),
    .cmd_i               (cmd_i),
    .clk_byp_ack_i       (clk_byp_ack_i),
    .cmd_credit_o        (cmd_credit_o),
    .domain_rst_active_o (domain_rst_active_o),
    .fault_mode_o        (fault_mode),
    .escalate_o          (escalate),
    .clk_sel_o           (clk_sel_o),
    .clk_switch_req_o    (clk_switch_req_o)
  );

  fuse_partition_ctrl #(
    .NUM_PARTS  (NUM_PARTS),
    .PART_WORDS (PART_WORDS)
  ) u_fuse_partition_ctrl (
    .clk           (clk),
    .cptra_rst_b   (cptra_rst_b),
    .domain_rst_i  (domain_rst_active_o),
    .escalate_i    (escalate),
    .req_i         (req_i),
    .req_write_i   (req_write_i),
    .addr_i        (addr_i),
    .wdata_i       (wdata_i),
    .enc_code_i    (enc_code),
    .dec_data_i    (dec_data),
    .dec_corr_i    (dec_corr),
    .dec_uncorr_i  (dec_uncorr),
    .arr_wr_en_o   (arr_wr_en),
    .arr_addr_o    (arr_addr),
    .arr_wr_code_o (arr_wr_code),
    .arr_rd_en_o   (arr_rd_en),
    .part_locked_o (part_locked),
    .enc_data_o    (enc_data),
    .busy_o        (busy_o),
    .rd_valid_o    (rd_valid_o),
    .rdata_o       (rdata_o),
    .corr_err_o    (corr_err_o),
    .uncorr_err_o  (uncorr_err_o),
    .scrap_o       (scrap_o)
  );

  otp_fuse_array #(
    .NUM_PARTS  (NUM_PARTS),
    .PART_WORDS (PART_WORDS)
  ) u_otp_fuse_array (
    .clk           (clk),
    .cptra_rst_b   (cptra_rst_b),
    .wr_en_i       (arr_wr_en),
    .wr_addr_i     (arr_addr),
    .wr_code_i     (arr_wr_code),
    .rd_en_i       (arr_rd_en),
    .rd_addr_i     (arr_addr),
    .fault_mode_i  (fault_mode),
    .part_locked_i (part_locked),
    .rd_code_o     (arr_rd_code)
  );

  otp_ecc_codec u_otp_ecc_codec (
    .enc_data_i   (enc_data),
    .dec_code_i   (arr_rd_code),
    .enc_code_o   (enc_code),
    .dec_data_o   (dec_data),
    .dec_corr_o   (dec_corr),
    .dec_uncorr_o (dec_uncorr)
  );

endmodule

`default_nettype wire

// File: dv/fuse_ss_tb.sv
// Directed testbench for the fuse subsystem with clock, reset, driver tasks, checks and summary
`default_nettype none

module fuse_ss_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_PARTS   = fuse_ss_pkg::NUM_PARTS;
  localparam int PART_WORDS  = fuse_ss_pkg::PART_WORDS;
  localparam int CMD_CREDITS = fuse_ss_pkg::CMD_CREDITS;
  localparam int RST_CYCLES  = fuse_ss_pkg::RST_CYCLES;
  localparam int DEPTH       = NUM_PARTS * PART_WORDS;
  localparam int ADDR_W      = $clog2(DEPTH);
  localparam int TIMEOUT     = 100;

  logic                  clk;
  logic                  cptra_rst_b;
  logic                  cmd_valid_i;
  fuse_ss_pkg::svc_cmd_e cmd_i;
  logic                  cmd_credit_o;
  logic                  req_i;
  logic                  req_write_i;
  logic [ADDR_W-1:0]     addr_i;
  logic [15:0]           wdata_i;
  logic                  busy_o;
  logic                  rd_valid_o;
  logic [15:0]           rdata_o;
  logic                  corr_err_o;
  logic                  uncorr_err_o;
  logic                  scrap_o;
  fuse_ss_pkg::clk_sel_e clk_sel_o;
  logic                  clk_switch_req_o;
  logic                  clk_byp_ack_i;
  logic                  domain_rst_active_o;

  int          errors;
  int          checks;
  int          sent;
  int          returned;
  int          rst_run;
  int          last_rst_len;
  logic [15:0] exp_mem [DEPTH];
  logic        locked_m [NUM_PARTS];
  logic        scrap_m;

  fuse_ss_top #(
    .NUM_PARTS   (NUM_PARTS),
    .PART_WORDS  (PART_WORDS),
    .CMD_CREDITS (CMD_CREDITS),
    .RST_CYCLES  (RST_CYCLES)
  ) DUT (
    .clk                 (clk),
    .cptra_rst_b         (cptra_rst_b),
    .cmd_valid_i         (cmd_valid_i),
    .cmd_i               (cmd_i),
    .cmd_credit_o        (cmd_credit_o),
    .req_i               (req_i),
    .req_write_i         (req_write_i),
    .addr_i              (addr_i),
    .wdata_i             (wdata_i),
    .busy_o              (busy_o),
    .rd_valid_o          (rd_valid_o),
    .rdata_o             (rdata_o),
    .corr_err_o          (corr_err_o),
    .uncorr_err_o        (uncorr_err_o),
    .scrap_o             (scrap_o),
    .clk_sel_o           (clk_sel_o),
    .clk_switch_req_o    (clk_switch_req_o),
    .clk_byp_ack_i       (clk_byp_ack_i),
    .domain_rst_active_o (domain_rst_active_o)
  );

  always #20 clk = ~clk;

  // Credits come back and the domain reset length is measured on pre-edge values
  always @(posedge clk) begin
    if (cmd_credit_o) begin
      returned++;
    end
    if (cmd_credit_o && domain_rst_active_o) begin
      errors++;
      $display("Credit returned while the domain reset was active at t=%0t", $time);
    end
    if (domain_rst_active_o) begin
      rst_run++;
    end else if (rst_run != 0) begin
      last_rst_len = rst_run;
      rst_run      = 0;
    end
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  function automatic logic [15:0] rand_word();
    return 16'($urandom());
  endfunction

  task automatic send_cmd(input fuse_ss_pkg::svc_cmd_e c);
    int n;
    n = 0;
    while ((sent - returned) >= CMD_CREDITS && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if ((sent - returned) >= CMD_CREDITS) begin
      errors++;
      $display("No command credit came back, command %s not sent", c.name());
    end else begin
      cmd_valid_i = 1'b1;
      cmd_i       = c;
      sent++;
      @(negedge clk);
      cmd_valid_i = 1'b0;
    end
  endtask

  // Returns once every queued command has been popped and has taken effect
  task automatic drain_cmds();
    int n;
    n = 0;
    while (returned != sent && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (returned != sent) begin
      errors++;
      $display("Command queue did not drain, %0d sent and %0d credits back", sent, returned);
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy_o && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (busy_o) begin
      errors++;
      $display("Controller stayed busy at t=%0t", $time);
    end
  endtask

  task automatic prog_word(input int a, input logic [15:0] d);
    int n;
    int p;
    p = a / PART_WORDS;
    wait_idle();
    req_i       = 1'b1;
    req_write_i = 1'b1;
    addr_i      = ADDR_W'(a);
    wdata_i     = d;
    n           = 0;
    do begin
      @(negedge clk);
      req_i = 1'b0;
      n++;
    end while (busy_o && n < TIMEOUT);
    check_val("busy_o program cycles", n, 2);
    // Locked or scrapped partitions keep their contents
    if (!locked_m[p] && !scrap_m) begin
      exp_mem[a] = d;
      if ((a % PART_WORDS) == PART_WORDS - 1 && d != 16'h0000) begin
        locked_m[p] = 1'b1;
      end
    end
  endtask

  task automatic read_word(input int a, output logic [15:0] data, output logic corr,
                           output logic uncorr);
    int lat;
    wait_idle();
    req_i       = 1'b1;
    req_write_i = 1'b0;
    addr_i      = ADDR_W'(a);
    lat         = 0;
    do begin
      @(negedge clk);
      req_i = 1'b0;
      lat++;
    end while (!rd_valid_o && lat < TIMEOUT);
    data   = rdata_o;
    corr   = corr_err_o;
    uncorr = uncorr_err_o;
    if (!rd_valid_o) begin
      errors++;
      $display("Read of address %0d never raised rd_valid_o", a);
    end else begin
      check_val("rd_valid_o latency", lat, 3);
    end
  endtask

  task automatic check_read(input int a, input logic [15:0] exp_data, input logic exp_corr,
                            input logic exp_uncorr);
    logic [15:0] data;
    logic        corr;
    logic        uncorr;
    read_word(a, data, corr, uncorr);
    check_val($sformatf("rdata_o @%0d", a), data, exp_data);
    check_val($sformatf("corr_err_o @%0d", a), corr, exp_corr);
    check_val($sformatf("uncorr_err_o @%0d", a), uncorr, exp_uncorr);
  endtask

  task automatic verify_all();
    for (int a = 0; a < DEPTH; a++) begin
      check_read(a, exp_mem[a], 1'b0, 1'b0);
    end
  endtask

  // ----------------------------------------------------------
  // Tests
  // ----------------------------------------------------------
  task automatic test_program_read();
    for (int p = 0; p < NUM_PARTS; p++) begin
      for (int w = 0; w < 3; w++) begin
        prog_word(p * PART_WORDS + w, rand_word());
      end
    end
    verify_all();
  endtask

  task automatic test_locking();
    // Partitions 0 and 1 get a digest, 2 and 3 stay open
    prog_word(0 * PART_WORDS + PART_WORDS - 1, rand_word() | 16'h0001);
    prog_word(1 * PART_WORDS + PART_WORDS - 1, rand_word() | 16'h0001);
    prog_word(0, ~exp_mem[0]);
    prog_word(1 * PART_WORDS + 5, rand_word() | 16'h0001);
    prog_word(3 * PART_WORDS + 5, rand_word() | 16'h0001);
    check_read(0, exp_mem[0], 1'b0, 1'b0);
    check_read(1 * PART_WORDS + 5, 16'h0000, 1'b0, 1'b0);
    check_read(3 * PART_WORDS + 5, exp_mem[3 * PART_WORDS + 5], 1'b0, 1'b0);
    verify_all();
  endtask

  task automatic test_fault_injection();
    logic [15:0] data;
    logic        corr;
    logic        uncorr;
    send_cmd(fuse_ss_pkg::FAULT_CORRECTABLE);
    drain_cmds();
    for (int p = 0; p < NUM_PARTS; p++) begin
      check_read(p * PART_WORDS, exp_mem[p * PART_WORDS], locked_m[p], 1'b0);
    end
    check_read(1, exp_mem[1], 1'b0, 1'b0);

    // A second fault mode does not replace the one already active
    send_cmd(fuse_ss_pkg::FAULT_UNCORRECTABLE);
    drain_cmds();
    check_read(0, exp_mem[0], 1'b1, 1'b0);

    send_cmd(fuse_ss_pkg::FAULT_CLEAR);
    send_cmd(fuse_ss_pkg::FAULT_UNCORRECTABLE);
    drain_cmds();
    for (int p = 0; p < NUM_PARTS; p++) begin
      read_word(p * PART_WORDS, data, corr, uncorr);
      check_val($sformatf("corr_err_o @%0d", p * PART_WORDS), corr, 1'b0);
      check_val($sformatf("uncorr_err_o @%0d", p * PART_WORDS), uncorr, locked_m[p]);
      if (!locked_m[p]) begin
        check_val($sformatf("rdata_o @%0d", p * PART_WORDS), data, exp_mem[p * PART_WORDS]);
      end
    end

    send_cmd(fuse_ss_pkg::FAULT_CLEAR);
    drain_cmds();
    verify_all();
  endtask

  task automatic test_domain_reset();
    send_cmd(fuse_ss_pkg::FAULT_CORRECTABLE);
    drain_cmds();
    last_rst_len = 0;
    send_cmd(fuse_ss_pkg::DOMAIN_RESET);
    send_cmd(fuse_ss_pkg::NOP);
    send_cmd(fuse_ss_pkg::NOP);
    send_cmd(fuse_ss_pkg::NOP);
    drain_cmds();
    @(negedge clk);
    check_val("domain_rst_active_o cycles", last_rst_len, RST_CYCLES + 1);
    check_val("credits returned", returned, sent);
    // Clean reads show the fault mode went back to NONE and the fuses survived
    verify_all();
  endtask

  task automatic switch_clock(input fuse_ss_pkg::svc_cmd_e c, input fuse_ss_pkg::clk_sel_e sel);
    send_cmd(c);
    drain_cmds();
    check_val("clk_sel_o", clk_sel_o, sel);
    check_val("clk_switch_req_o", clk_switch_req_o, 1'b1);
    repeat (3) @(negedge clk);
    check_val("clk_switch_req_o", clk_switch_req_o, 1'b1);
    clk_byp_ack_i = 1'b1;
    @(negedge clk);
    clk_byp_ack_i = 1'b0;
    check_val("clk_switch_req_o", clk_switch_req_o, 1'b0);
  endtask

  task automatic test_clock_select();
    switch_clock(fuse_ss_pkg::CLK_160, fuse_ss_pkg::MHZ_160);
    switch_clock(fuse_ss_pkg::CLK_400, fuse_ss_pkg::MHZ_400);
    switch_clock(fuse_ss_pkg::CLK_500, fuse_ss_pkg::MHZ_500);
    switch_clock(fuse_ss_pkg::CLK_1000, fuse_ss_pkg::MHZ_1000);
  endtask

  task automatic test_escalation();
    int n;
    send_cmd(fuse_ss_pkg::ESCALATE);
    drain_cmds();
    n = 0;
    while (!scrap_o && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    check_val("scrap_o", scrap_o, 1'b1);
    scrap_m = 1'b1;
    check_read(1, 16'h0000, 1'b0, 1'b1);
    check_read(3 * PART_WORDS + 5, 16'h0000, 1'b0, 1'b1);
    prog_word(2 * PART_WORDS + 6, rand_word() | 16'h0001);

    send_cmd(fuse_ss_pkg::DOMAIN_RESET);
    drain_cmds();
    n = 0;
    while (domain_rst_active_o && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (domain_rst_active_o) begin
      errors++;
      $display("Domain reset did not end after escalation");
    end
    scrap_m = 1'b0;
    check_val("scrap_o", scrap_o, 1'b0);
    verify_all();
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    int seed_q;
    clk           = 1'b0;
    cptra_rst_b   = 1'b0;
    cmd_valid_i   = 1'b0;
    cmd_i         = fuse_ss_pkg::NOP;
    req_i         = 1'b0;
    req_write_i   = 1'b0;
    addr_i        = '0;
    wdata_i       = '0;
    clk_byp_ack_i = 1'b0;
    errors        = 0;
    checks        = 0;
    sent          = 0;
    returned      = 0;
    rst_run       = 0;
    last_rst_len  = 0;
    scrap_m       = 1'b0;
    seed_q        = $urandom(32'h7dda_3c48);
    for (int a = 0; a < DEPTH; a++) begin
      exp_mem[a] = 16'h0000;
    end
    for (int p = 0; p < NUM_PARTS; p++) begin
      locked_m[p] = 1'b0;
    end

    repeat (8) @(negedge clk);
    cptra_rst_b = 1'b1;
    @(negedge clk);
    check_val("cmd_credit_o", cmd_credit_o, 1'b0);
    check_val("domain_rst_active_o", domain_rst_active_o, 1'b0);
    check_val("clk_switch_req_o", clk_switch_req_o, 1'b0);
    check_val("busy_o", busy_o, 1'b0);
    check_val("rd_valid_o", rd_valid_o, 1'b0);
    check_val("corr_err_o", corr_err_o, 1'b0);
    check_val("uncorr_err_o", uncorr_err_o, 1'b0);
    check_val("scrap_o", scrap_o, 1'b0);
    check_val("clk_sel_o", clk_sel_o, fuse_ss_pkg::MHZ_1000);

    test_program_read();
    test_locking();
    test_fault_injection();
    test_domain_reset();
    test_clock_select();
    test_escalation();

    repeat (2) @(negedge clk);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: fuse_ss_top.f
src/fuse_ss_pkg.sv
src/svc_cmd_decoder.sv
src/otp_ecc_codec.sv
src/otp_fuse_array.sv
src/fuse_partition_ctrl.sv
src/fuse_ss_top.sv
dv/fuse_ss_tb.sv
